// ==== bench/rpDriveTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Table-driven testbench for the RP drive register and error section
// Expected values come from a reference model of the register rules
// Inputs change 5 ns after the rising edge
// Outputs are sampled on the falling edge
// Stops at the first mismatch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rpDrive_defs.svh"

module rpDriveTb
   import rpPkg::*;
();

   // Row kinds
   localparam logic [1:0] opWrite  = 2'd0;
   localparam logic [1:0] opSector = 2'd1;
   localparam logic [1:0] opClear  = 2'd2;

   // ER1 bit positions with a set strobe
   localparam int bitIlf = 0;
   localparam int bitRmr = 2;
   localparam int bitPar = 3;
   localparam int bitAoe = 9;
   localparam int bitIae = 10;
   localparam int bitWle = 11;

   localparam int maxRows = 28;
   localparam longint watchdogNs = (maxRows + 20) * 40 * 8;

   logic     clk;
   logic     rst;
   logic     clr;
   logic     regWrite;
   logic [2:0] regSel;
   rpWord_t  dataIn;
   logic     busParity;
   logic     drvReady;
   logic     writeLock;
   logic     sectorDone;
   rpEr1_t   er1;
   logic     attn;
   rpSect_t  daSect;
   rpTrk_t   daTrk;
   logic     goPulse;
   logic [4:0] goFunc;

   // Stimulus table, one row per operation
   int          nRows;
   logic [1:0]  rowOp    [maxRows];
   logic [2:0]  rowSel   [maxRows];
   logic [35:0] rowData  [maxRows];
   logic        rowParOk [maxRows];
   logic        rowReady [maxRows];
   logic        rowLock  [maxRows];
   int          rowCount [maxRows];

   // Reference model state
   rpEr1_t  expEr1;
   rpSect_t expSect;
   rpTrk_t  expTrk;
   integer  seed;

   rpDrive u_rpDrive (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .regWrite   (regWrite),
      .regSel     (regSel),
      .dataIn     (dataIn),
      .busParity  (busParity),
      .drvReady   (drvReady),
      .writeLock  (writeLock),
      .sectorDone (sectorDone),
      .er1        (er1),
      .attn       (attn),
      .daSect     (daSect),
      .daTrk      (daTrk),
      .goPulse    (goPulse),
      .goFunc     (goFunc)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////
   // Failure handling and checks
   ////////////////////////////////////////////////////////////////////////

   task automatic failRun();
   begin
      $display("Something failed");
      $fatal(1);
   end
   endtask

   task automatic checkEr1(input rpEr1_t exp);
   begin
      if (er1 !== exp)
      begin
         $display("** Error at %0t ns: er1 expected %h, got %h", $time, exp, er1);
         failRun();
      end
      // attn is the OR of the register
      if (attn !== (|exp))
      begin
         $display("** Error at %0t ns: attn expected %b, got %b", $time, |exp, attn);
         failRun();
      end
   end
   endtask

   task automatic checkDa(input rpSect_t expS, input rpTrk_t expT);
   begin
      if (daSect !== expS)
      begin
         $display("** Error at %0t ns: daSect expected %0d, got %0d", $time, expS, daSect);
         failRun();
      end
      if (daTrk !== expT)
      begin
         $display("** Error at %0t ns: daTrk expected %0d, got %0d", $time, expT, daTrk);
         failRun();
      end
   end
   endtask

   task automatic checkGo(input logic expPulse, input logic [4:0] expFunc);
   begin
      if (goPulse !== expPulse)
      begin
         $display("** Error at %0t ns: goPulse expected %b, got %b", $time, expPulse, goPulse);
         failRun();
      end
      // Function only matters with a pulse
      if (expPulse && (goFunc !== expFunc))
      begin
         $display("** Error at %0t ns: goFunc expected %0d, got %0d", $time, expFunc, goFunc);
         failRun();
      end
   end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Function codes and bus words
   ////////////////////////////////////////////////////////////////////////

   function automatic logic funIsLegal(input logic [4:0] f);
   begin
      case (f)
         `RP_FUN_NOP, `RP_FUN_SEEK, `RP_FUN_RECAL, `RP_FUN_DRVCLR, `RP_FUN_SEARCH,
         `RP_FUN_WRCHK, `RP_FUN_WRITE, `RP_FUN_READ:
            funIsLegal = 1'b1;
         default:
            funIsLegal = 1'b0;
      endcase
   end
   endfunction

   // Functions that write the media
   function automatic logic funIsMediaWrite(input logic [4:0] f);
   begin
      funIsMediaWrite = (f == `RP_FUN_WRITE) || (f == `RP_FUN_WRCHK);
   end
   endfunction

   function automatic logic [35:0] csWord(input logic [4:0] fun, input logic go);
   begin
      csWord = {30'd0, fun, go};
   end
   endfunction

   function automatic logic [35:0] daWord(input logic [5:0] sect, input logic [4:0] trk);
   begin
      daWord = {23'd0, trk, 2'b00, sect};
   end
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////////

   task automatic addRow(input logic [1:0] op, input logic [2:0] sel, input logic [35:0] data,
                         input logic parOk, input logic ready, input logic lock, input int count);
   begin
      if (nRows >= maxRows)
      begin
         $display("Stimulus table is full, row %0d does not fit", nRows);
         failRun();
      end
      rowOp[nRows]    = op;
      rowSel[nRows]   = sel;
      rowData[nRows]  = data;
      rowParOk[nRows] = parOk;
      rowReady[nRows] = ready;
      rowLock[nRows]  = lock;
      rowCount[nRows] = count;
      nRows = nRows + 1;
   end
   endtask

   task automatic buildTable();
      logic [63:0] r0;
      logic [63:0] r1;
      logic [63:0] r2;
      logic [5:0]  sect;
      logic [4:0]  trk;
   begin
      nRows = 0;
      r0 = {$random(seed), $random(seed)};
      r1 = {$random(seed), $random(seed)};
      r2 = {$random(seed), $random(seed)};
      // ER1 write loads when ready, ignored when not, then cleaned
      addRow(opWrite, `RP_SEL_ER1, r0[35:0], 1'b1, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_ER1, r1[35:0], 1'b1, 1'b0, 1'b0, 0);
      addRow(opWrite, `RP_SEL_ER1, 36'd0, 1'b1, 1'b1, 1'b0, 0);
      // Go function decode
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_READ, 1'b1), 1'b1, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_SEEK, 1'b1), 1'b1, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_CS1, csWord(5'd7, 1'b1), 1'b1, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_WRITE, 1'b1), 1'b1, 1'b1, 1'b1, 0);
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_WRCHK, 1'b1), 1'b1, 1'b1, 1'b0, 0);
      // Refused while not ready
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_READ, 1'b1), 1'b1, 1'b0, 1'b0, 0);
      sect = 6'($unsigned($random(seed)) % 20);
      trk  = 5'($unsigned($random(seed)) % 19);
      addRow(opWrite, `RP_SEL_DA, daWord(sect, trk), 1'b1, 1'b0, 1'b0, 0);
      // Bad parity still lets the write land
      addRow(opWrite, `RP_SEL_ER1, 36'd0, 1'b0, 1'b1, 1'b0, 0);
      sect = 6'($unsigned($random(seed)) % 20);
      trk  = 5'($unsigned($random(seed)) % 19);
      addRow(opWrite, `RP_SEL_DA, daWord(sect, trk), 1'b0, 1'b1, 1'b0, 0);
      // Out of range sector, then track
      addRow(opWrite, `RP_SEL_DA, daWord(6'd25, 5'd3), 1'b1, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_DA, daWord(6'd4, 5'd19), 1'b1, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_DRVCLR, 1'b1), 1'b1, 1'b1, 1'b0, 0);
      sect = 6'($unsigned($random(seed)) % 20);
      trk  = 5'($unsigned($random(seed)) % 19);
      addRow(opWrite, `RP_SEL_DA, daWord(sect, trk), 1'b1, 1'b1, 1'b0, 0);
      // Sector stepping with track carry, then overflow
      addRow(opWrite, `RP_SEL_DA, daWord(6'd18, 5'd17), 1'b1, 1'b1, 1'b0, 0);
      addRow(opSector, 3'd0, 36'd0, 1'b1, 1'b1, 1'b0, 3);
      addRow(opWrite, `RP_SEL_DA, daWord(6'd19, 5'd18), 1'b1, 1'b1, 1'b0, 0);
      addRow(opSector, 3'd0, 36'd0, 1'b1, 1'b1, 1'b0, 1);
      // Clears beat a set strobe in the same cycle
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_DRVCLR, 1'b1), 1'b0, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_ER1, r2[35:0], 1'b1, 1'b1, 1'b0, 0);
      addRow(opClear, `RP_SEL_ER1, r2[35:0], 1'b0, 1'b1, 1'b0, 0);
      addRow(opWrite, `RP_SEL_CS1, csWord(`RP_FUN_NOP, 1'b0), 1'b1, 1'b1, 1'b0, 0);
   end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Row application and reference model
   ////////////////////////////////////////////////////////////////////////

   task automatic applyRow(input int i);
      logic [35:0] data;
      logic [4:0]  fun;
      logic        ready;
      logic        cs1Go;
      logic        wle;
      logic        dclr;
      logic        go;
      logic        er1w;
      logic        daw;
      logic        iae;
      logic        aoe;
      rpEr1_t      mask;
   begin
      data  = rowData[i];
      fun   = data[5:1];
      ready = rowReady[i];
      if (rowOp[i] == opSector)
      begin
         aoe = 1'b0;
         for (int k = 0; k < rowCount[i]; k++)
         begin
            @(posedge clk);
            // AOE of an earlier pulse lands on this edge
            if (aoe)
               expEr1[bitAoe] = 1'b1;
            #5 sectorDone = 1'b1;
            @(posedge clk);
            #5 sectorDone = 1'b0;
            // Step sector, carry into track, wrap past the last track
            if (expSect >= `RP_NSECT - 6'd1)
            begin
               expSect = '0;
               if (expTrk >= `RP_NTRK - 5'd1)
               begin
                  expTrk = '0;
                  aoe = 1'b1;
               end
               else
                  expTrk = expTrk + 5'd1;
            end
            else
               expSect = expSect + 6'd1;
            @(negedge clk);
            checkDa(expSect, expTrk);
            // AOE of this pulse is still one edge away
            checkEr1(expEr1);
         end
         @(posedge clk);
         if (aoe)
            expEr1[bitAoe] = 1'b1;
         @(negedge clk);
         checkEr1(expEr1);
      end
      else
      begin
         @(posedge clk);
         #5;
         clr       = (rowOp[i] == opClear);
         regWrite  = 1'b1;
         regSel    = rowSel[i];
         dataIn    = data;
         drvReady  = ready;
         writeLock = rowLock[i];
         // Odd parity over data[17:0] and busParity is good
         busParity = rowParOk[i] ? ~(^data[17:0]) : ^data[17:0];

         cs1Go = (rowSel[i] == `RP_SEL_CS1) && data[0];
         wle   = cs1Go && ready && funIsLegal(fun) && funIsMediaWrite(fun) && rowLock[i];
         dclr  = cs1Go && ready && (fun == `RP_FUN_DRVCLR);
         go    = cs1Go && ready && funIsLegal(fun) && !wle && !dclr;
         er1w  = (rowSel[i] == `RP_SEL_ER1) && ready;
         daw   = (rowSel[i] == `RP_SEL_DA) && ready;
         iae   = daw && ((data[5:0] >= `RP_NSECT) || (data[12:8] >= `RP_NTRK));
         mask  = '0;
         mask[bitIlf] = cs1Go && ready && !funIsLegal(fun);
         mask[bitWle] = wle;
         mask[bitRmr] = (cs1Go || (rowSel[i] == `RP_SEL_DA)) && !ready;
         mask[bitPar] = !rowParOk[i];

         @(negedge clk);
         checkGo(go, fun);

         @(posedge clk);
         #5;
         clr      = 1'b0;
         regWrite = 1'b0;
         // Clear first, then set strobes over written data
         if (rowOp[i] == opClear)
         begin
            expEr1  = '0;
            expSect = '0;
            expTrk  = '0;
            iae     = 1'b0;
         end
         else if (dclr)
            expEr1 = '0;
         else if (er1w)
            expEr1 = mask | data[15:0];
         else
            expEr1 = expEr1 | mask;
         if (daw && (rowOp[i] != opClear))
         begin
            expSect = data[5:0];
            expTrk  = data[12:8];
         end
         @(negedge clk);
         checkEr1(expEr1);
         checkDa(expSect, expTrk);
         checkGo(1'b0, 5'd0);

         // IAE lands one cycle after the CS1-caused bits
         @(posedge clk);
         if (iae)
            expEr1[bitIae] = 1'b1;
         @(negedge clk);
         checkEr1(expEr1);
      end
   end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      clr        = 1'b0;
      regWrite   = 1'b0;
      regSel     = 3'd0;
      dataIn     = '0;
      busParity  = 1'b0;
      drvReady   = 1'b1;
      writeLock  = 1'b0;
      sectorDone = 1'b0;
      expEr1     = '0;
      expSect    = '0;
      expTrk     = '0;
      seed       = 61;
      buildTable();

      repeat (4) @(posedge clk);
      #5 rst = 1'b0;
      @(negedge clk);
      checkEr1('0);
      checkDa('0, '0);
      checkGo(1'b0, 5'd0);

      for (int i = 0; i < nRows; i++)
         applyRow(i);

      $display("Everything OK");
      $finish;
   end

   // Watchdog scaled from the table size
   initial
   begin
      #(watchdogNs);
      $display("Timeout, the run did not finish in %0d ns", watchdogNs);
      failRun();
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/rpPkg.sv
rtl/rpCmdCheck.sv
rtl/rpAddrCheck.sv
rtl/rpErr1.sv
rtl/rpDrive.sv
bench/rpDriveTb.sv

// ==== rtl/rpAddrCheck.sv ====
////////////////////////////////////////////////////////////////////////////
// Desired sector/track register with range check and sector stepping
// setIae and setAoe are registered, one cycle after their cause
// clr wins over a DA write, a DA write wins over sectorDone
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rpDrive_defs.svh"

module rpAddrCheck
   import rpPkg::*;
(
   input  wire       clk,
   input  wire       rst,
   input  wire       clr,
   input  wire       daWrite,
   input  rpWord_t   dataIn,
   input  wire       sectorDone,
   output rpSect_t   daSect,
   output rpTrk_t    daTrk,
   output logic      setIae,
   output logic      setAoe
);

   logic addrBad;
   logic lastSect;
   logic lastTrk;

   // Written address outside the drive geometry
   assign addrBad = (dataIn.da.sect >= `RP_NSECT) || (dataIn.da.trk >= `RP_NTRK);

   // Last sector of the track, or beyond after a bad write
   assign lastSect = daSect >= (`RP_NSECT - 6'd1);
   // Last track of the cylinder
   assign lastTrk  = daTrk >= (`RP_NTRK - 5'd1);

   ////////////////////////////////////////////////////////////////////////
   // Address register
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         daSect <= '0;
         daTrk  <= '0;
         setIae <= 1'b0;
         setAoe <= 1'b0;
      end
      else
      begin
         // Strobes last one cycle
         setIae <= 1'b0;
         setAoe <= 1'b0;
         if (clr)
         begin
            daSect <= '0;
            daTrk  <= '0;
         end
         else if (daWrite)
         begin
            // Bad address is still loaded
            daSect <= dataIn.da.sect;
            daTrk  <= dataIn.da.trk;
            setIae <= addrBad;
         end
         else if (sectorDone)
         begin
            if (!lastSect)
               daSect <= daSect + 6'd1;
            else
            begin
               // Sector wraps, carry into track
               daSect <= '0;
               if (!lastTrk)
                  daTrk <= daTrk + 5'd1;
               else
               begin
                  // Ran off the cylinder
                  daTrk  <= '0;
                  setAoe <= 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/rpCmdCheck.sv ====
////////////////////////////////////////////////////////////////////////////
// Register write decode and CS1 function check, fully combinational
// All outputs are valid in the regWrite cycle only
// Bus parity is odd over dataIn[17:0] and busParity
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rpDrive_defs.svh"

module rpCmdCheck
   import rpPkg::*;
(
   input  wire          regWrite,
   input  wire [2:0]    regSel,
   input  rpWord_t      dataIn,
   input  wire          busParity,
   input  wire          drvReady,
   input  wire          writeLock,
   output logic         er1Write,
   output logic         daWrite,
   output logic         setIlf,
   output logic         setRmr,
   output logic         setWle,
   output logic         setPar,
   output logic         drvClr,
   output logic         goPulse,
   output logic [4:0]   goFunc
);

   logic cs1Go;
   logic funLegal;
   logic funWrite;
   logic parErr;

   // Go write to CS1, before the ready check
   assign cs1Go = regWrite && (regSel == `RP_SEL_CS1) && dataIn.cs1.go;

   // Even parity over the low half word plus parity bit is an error
   assign parErr = ~(^{dataIn[17:0], busParity});

   // Function presented with the CS1 write
   assign goFunc = dataIn.cs1.fun;

   ////////////////////////////////////////////////////////////////////////
   // Function classification
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      funLegal = 1'b0;
      funWrite = 1'b0;
      case (dataIn.cs1.fun)
         `RP_FUN_NOP, `RP_FUN_SEEK, `RP_FUN_RECAL, `RP_FUN_DRVCLR,
         `RP_FUN_SEARCH, `RP_FUN_READ:
            funLegal = 1'b1;
         // Writes to the media
         `RP_FUN_WRCHK, `RP_FUN_WRITE:
         begin
            funLegal = 1'b1;
            funWrite = 1'b1;
         end
         default:
            funLegal = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////
   // Strobes
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      // Register loads only when the drive is ready
      er1Write = regWrite && (regSel == `RP_SEL_ER1) && drvReady;
      daWrite  = regWrite && (regSel == `RP_SEL_DA) && drvReady;

      // Not ready, write refused
      setRmr = (cs1Go || (regWrite && (regSel == `RP_SEL_DA))) && !drvReady;

      // Bad parity flags the write but lets it through
      setPar = regWrite && parErr;

      // Go while ready, one outcome per function
      setIlf  = cs1Go && drvReady && !funLegal;
      setWle  = cs1Go && drvReady && funLegal && funWrite && writeLock;
      drvClr  = cs1Go && drvReady && (dataIn.cs1.fun == `RP_FUN_DRVCLR);
      goPulse = cs1Go && drvReady && funLegal && !(funWrite && writeLock)
                && (dataIn.cs1.fun != `RP_FUN_DRVCLR);
   end

endmodule

`default_nettype wire

// ==== rtl/rpDrive.sv ====
////////////////////////////////////////////////////////////////////////////
// RP drive register and error section, top level
// goPulse and goFunc are combinational in the regWrite cycle
// ER1 bits from CS1 writes land one cycle later, IAE and AOE two
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpDrive
   import rpPkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire          clr,
   input  wire          regWrite,
   input  wire [2:0]    regSel,
   input  rpWord_t      dataIn,
   input  wire          busParity,
   input  wire          drvReady,
   input  wire          writeLock,
   input  wire          sectorDone,
   output rpEr1_t       er1,
   output logic         attn,
   output rpSect_t      daSect,
   output rpTrk_t       daTrk,
   output logic         goPulse,
   output logic [4:0]   goFunc
);

   // Command checker to address checker and ER1
   logic er1Write;
   logic daWrite;
   logic setIlf;
   logic setRmr;
   logic setWle;
   logic setPar;
   logic drvClr;

   // Address checker to ER1
   logic setIae;
   logic setAoe;

   ////////////////////////////////////////////////////////////////////////
   // Checkers
   ////////////////////////////////////////////////////////////////////////

   rpCmdCheck uCmdCheck (
      .regWrite   (regWrite),
      .regSel     (regSel),
      .dataIn     (dataIn),
      .busParity  (busParity),
      .drvReady   (drvReady),
      .writeLock  (writeLock),
      .er1Write   (er1Write),
      .daWrite    (daWrite),
      .setIlf     (setIlf),
      .setRmr     (setRmr),
      .setWle     (setWle),
      .setPar     (setPar),
      .drvClr     (drvClr),
      .goPulse    (goPulse),
      .goFunc     (goFunc)
   );

   rpAddrCheck uAddrCheck (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .daWrite    (daWrite),
      .dataIn     (dataIn),
      .sectorDone (sectorDone),
      .daSect     (daSect),
      .daTrk      (daTrk),
      .setIae     (setIae),
      .setAoe     (setAoe)
   );

   // Error register collects both checkers
   rpErr1 uErr1 (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .drvClr     (drvClr),
      .er1Write   (er1Write),
      .dataIn     (dataIn),
      .setIlf     (setIlf),
      .setRmr     (setRmr),
      .setWle     (setWle),
      .setPar     (setPar),
      .setIae     (setIae),
      .setAoe     (setAoe),
      .er1        (er1),
      .attn       (attn)
   );

endmodule

`default_nettype wire

// ==== rtl/rpDrive_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// Register selects, CS1 function codes and geometry for one RP drive
// Codes not listed as RP_FUN_* are illegal functions
// Geometry limits are sized to the DA sector and track fields
////////////////////////////////////////////////////////////////////////////

`ifndef RPDRIVE_DEFS_SVH
`define RPDRIVE_DEFS_SVH

//////////////////////////////////////////////////////////////////////////
// Register selects
//////////////////////////////////////////////////////////////////////////

// Control/status 1
`define RP_SEL_CS1      3'd0
// Error register 1
`define RP_SEL_ER1      3'd2
// Desired sector/track address
`define RP_SEL_DA       3'd5

//////////////////////////////////////////////////////////////////////////
// CS1 function codes
//////////////////////////////////////////////////////////////////////////

`define RP_FUN_NOP      5'd0
`define RP_FUN_SEEK     5'd2
`define RP_FUN_RECAL    5'd3
`define RP_FUN_DRVCLR   5'd4
`define RP_FUN_SEARCH   5'd12
// Writes are refused under write lock
`define RP_FUN_WRCHK    5'd20
`define RP_FUN_WRITE    5'd24
`define RP_FUN_READ     5'd28

//////////////////////////////////////////////////////////////////////////
// Drive geometry
//////////////////////////////////////////////////////////////////////////

// Sectors per track, valid sectors 0 to 19
`define RP_NSECT        6'd20
// Tracks per cylinder, valid tracks 0 to 18
`define RP_NTRK         5'd19

`endif

// ==== rtl/rpErr1.sv ====
////////////////////////////////////////////////////////////////////////////
// Error register 1 with attention
// Priority per bit: clr or drvClr, then set strobe, then ER1 write
// Bits with no set strobe change only by a software write
// attn is combinational from the register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpErr1
   import rpPkg::*;
(
   input  wire       clk,
   input  wire       rst,
   input  wire       clr,
   input  wire       drvClr,
   input  wire       er1Write,
   input  rpWord_t   dataIn,
   input  wire       setIlf,
   input  wire       setRmr,
   input  wire       setWle,
   input  wire       setPar,
   input  wire       setIae,
   input  wire       setAoe,
   output rpEr1_t    er1,
   output logic      attn
);

   rpEr1_t setMask;
   rpEr1_t er1Next;
   logic   er1Clear;

   ////////////////////////////////////////////////////////////////////////
   // Set strobes mapped onto the ER1 bit positions
   ////////////////////////////////////////////////////////////////////////

   // Bit 15 DCK, 14 UNS, 13 OPI, 12 DTE
   // Bit 11 WLE, 10 IAE, 9 AOE
   // Bit 8 HCRC, 7 HCE, 6 ECH, 5 WCF, 4 FER
   // Bit 3 PAR, 2 RMR, 1 ILR, 0 ILF
   assign setMask = {
      // DCK UNS OPI DTE, software only
      4'b0000,
      // Write lock error
      setWle,
      // Invalid address error
      setIae,
      // Address overflow error
      setAoe,
      // HCRC HCE ECH WCF FER, software only
      5'b00000,
      // Bus parity error
      setPar,
      // Register modification refused
      setRmr,
      // ILR, software only
      1'b0,
      // Illegal function
      setIlf
   };

   // Controller clear or drive clear function
   assign er1Clear = clr || drvClr;

   ////////////////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      if (er1Clear)
         er1Next = '0;
      else if (er1Write)
         // Strobed bits win over the written value
         er1Next = setMask | rpEr1_t'(dataIn[15:0]);
      else
         // Strobed bits set, rest hold
         er1Next = setMask | er1;
   end

   ////////////////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else
         er1 <= er1Next;
   end

   // Any error raises attention
   assign attn = |er1;

endmodule

`default_nettype wire

// ==== rtl/rpPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Bus word and register types for the RP drive register section
// The 36-bit bus word is read either as CS1 or as DA
// ER1 bit order, high to low: DCK UNS OPI DTE WLE IAE AOE HCRC
//                             HCE ECH WCF FER PAR RMR ILR ILF
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rpPkg;

   // CS1 view of a bus write
   typedef struct packed {
      logic [35:6]  unused;
      // Function code
      logic [4:0]   fun;
      // Go bit, starts the function
      logic         go;
   } rpCs1_t;

   // DA view of a bus write
   typedef struct packed {
      logic [35:13] unused;
      // Desired track
      logic [4:0]   trk;
      logic [7:6]   rsvd;
      // Desired sector
      logic [5:0]   sect;
   } rpDa_t;

   // One bus data word, decoded by register select
   typedef union packed {
      rpCs1_t cs1;
      rpDa_t  da;
   } rpWord_t;

   // Error register 1
   typedef logic [15:0] rpEr1_t;

   // Desired address fields
   typedef logic [5:0]  rpSect_t;
   typedef logic [4:0]  rpTrk_t;

endpackage

`default_nettype wire
